/* flist.f */
+incdir+source
source/power_pkg.sv
source/regs_pkg.sv
source/seq_status_if.sv
source/reg_decode.sv
source/rail_sequencer.sv
source/rail_io_map.sv
source/pwr_seq_top.sv
tb/tb_pwr_seq.sv

/* run.sh */
#!/bin/sh
# Compiles the power sequencer testbench with Verilator and runs it.
# The result is read from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_pwr_seq \
	-f flist.f --Mdir obj_dir -o tb_pwr_seq
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_pwr_seq > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF '>>> PASS' "$LOG"; then
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1

/* source/power_pkg.sv */
/*
 * Rail-side types shared by the sequencer, the pin map and the status
 * interface. Refer to them with power_pkg:: scoped names.
 */
`include "pwr_seq_defines.svh"

package power_pkg;

	// One bit per logical rail, bit 0 powers up first
	typedef logic [`RAIL_COUNT-1:0] rail_vec_t;

	// Sequencer error flags
	typedef struct packed {
		logic wait_err;
		logic operation_err;
		logic err_found;
	} seq_err_t;

	// Rails fed only to the second CPU: 3, 6, 8, 10, 12 and 14
	localparam rail_vec_t cpub_rail_mask = 15'b101_0101_0100_1000;

endpackage

/* source/pwr_seq_defines.svh */
/*
 * Build constants for the power sequencer: rail count, timer lengths and
 * register map. Include it in any file that needs these values.
 * The timer counts are short so that simulation stays quick.
 */
`ifndef PWR_SEQ_DEFINES_SVH
`define PWR_SEQ_DEFINES_SVH

// Logical rails, rail 0 is the ATX supply
`define RAIL_COUNT 15

// Timer lengths in clk_in cycles
`define SETTLE_CYCLES 16
`define WATCHDOG_CYCLES 64

// Register map
`define ADDR_VERSION 8'h00
`define ADDR_CLR_ERR 8'h03
`define ADDR_PG_LATCH_HI 8'h05
`define ADDR_STATUS 8'h07
`define ADDR_EN_LO 8'h08
`define ADDR_PG_LO 8'h0A
`define ADDR_VENDOR 8'h0C

`endif

/* source/pwr_seq_top.sv */
/*
 * Top level of the board power sequencer. Connects the sequencer, the pin
 * map and the register decoder to the board pins and the register port.
 */
module pwr_seq_top (
	input logic clk_in,
	input logic arst_n,
	input logic sysen,
	input logic cpub_present_n,
	input logic bmc_software_pg,
	input power_pkg::rail_vec_t board_pg,
	input logic reg_sel,
	input regs_pkg::reg_addr_t reg_addr,
	input logic reg_rd,
	output power_pkg::rail_vec_t board_en,
	output logic cpub_clk_oe,
	output logic sysgood,
	output logic lpc_rst,
	output regs_pkg::reg_byte_t reg_rdata
);

	power_pkg::rail_vec_t rail_en;
	power_pkg::rail_vec_t rail_pg;
	logic cpub_present;

	seq_status_if sif ();

	rail_sequencer u_seq (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.sysen(sysen),
		.rail_pg(rail_pg),
		.bmc_software_pg(bmc_software_pg),
		.status(sif.sequencer),
		.rail_en(rail_en),
		.sysgood(sysgood)
	);

	rail_io_map u_io (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.cpub_present_n(cpub_present_n),
		.rail_en(rail_en),
		.board_pg(board_pg),
		.board_en(board_en),
		.rail_pg(rail_pg),
		.cpub_present(cpub_present),
		.cpub_clk_oe(cpub_clk_oe)
	);

	reg_decode u_regs (
		.clk_in(clk_in),
		.arst_n(arst_n),
		.reg_sel(reg_sel),
		.reg_addr(reg_addr),
		.reg_rd(reg_rd),
		.cpub_present(cpub_present),
		.status(sif.decoder),
		.reg_rdata(reg_rdata)
	);

	// LPC reset releases with the internal power good
	assign lpc_rst = sif.sysgood_int;

endmodule

/* source/rail_io_map.sv */
/*
 * Maps logical rails onto board pins. Rail 0 drives the active-low ATX pin,
 * second-CPU rails are held off when that CPU is absent and their
 * power-good is forced so the sequence still completes.
 */
`include "pwr_seq_defines.svh"

module rail_io_map (
	input logic clk_in,
	input logic arst_n,
	input logic cpub_present_n,
	input power_pkg::rail_vec_t rail_en,
	input power_pkg::rail_vec_t board_pg,
	output power_pkg::rail_vec_t board_en,
	output power_pkg::rail_vec_t rail_pg,
	output logic cpub_present,
	output logic cpub_clk_oe
);

	// Pin polarity, only the ATX pin is inverted
	localparam power_pkg::rail_vec_t ACTIVE_LOW = power_pkg::rail_vec_t'(1);

	power_pkg::rail_vec_t absent_mask;

	assign absent_mask = power_pkg::cpub_rail_mask & {`RAIL_COUNT{~cpub_present}};

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			board_en <= ACTIVE_LOW;
			rail_pg <= '0;
			cpub_present <= 1'b0;
			cpub_clk_oe <= 1'b0;
		end else begin
			board_en <= (rail_en & ~absent_mask) ^ ACTIVE_LOW;
			// Missing rails report good as soon as they are asked for
			rail_pg <= board_pg | (absent_mask & rail_en);
			cpub_present <= ~cpub_present_n;
			cpub_clk_oe <= ~cpub_present_n;
		end
	end

endmodule

/* source/rail_sequencer.sv */
/*
 * Rail power sequencer. Brings rails up in index order once sysen is high,
 * each after the previous rail has held power-good for the settle time,
 * and drops them from the top when sysen falls. A watchdog and a lost
 * power-good check latch errors that hold every rail off until cleared.
 */
`include "pwr_seq_defines.svh"

module rail_sequencer (
	input logic clk_in,
	input logic arst_n,
	input logic sysen,
	input power_pkg::rail_vec_t rail_pg,
	input logic bmc_software_pg,
	seq_status_if.sequencer status,
	output power_pkg::rail_vec_t rail_en,
	output logic sysgood
);

	localparam int D_W = $clog2(`SETTLE_CYCLES + 1);
	localparam int W_W = $clog2(`WATCHDOG_CYCLES + 1);
	localparam int RC = `RAIL_COUNT;

	logic sysen_s1, sysen_s2;
	power_pkg::rail_vec_t pg_s1, pg_s2;
	power_pkg::rail_vec_t delay_done, pg_latch;
	power_pkg::rail_vec_t settle_req, settle_sel, wait_req, en_next;
	power_pkg::seq_err_t err;
	logic [D_W-1:0] d_count;
	logic [W_W-1:0] w_count;
	logic sysgood_int;

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			sysen_s1 <= 1'b0;
			sysen_s2 <= 1'b0;
			pg_s1 <= '0;
			pg_s2 <= '0;
		end else begin
			sysen_s1 <= sysen;
			sysen_s2 <= sysen_s1;
			pg_s1 <= rail_pg;
			pg_s2 <= pg_s1;
		end
	end

	// Settling has priority over waiting, lowest rail first
	assign settle_req = pg_s2 & rail_en & ~delay_done;
	assign settle_sel = settle_req & (~settle_req + power_pkg::rail_vec_t'(1));
	assign wait_req = ~pg_s2 & rail_en;

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			delay_done <= '0;
			d_count <= '0;
			w_count <= '0;
			err <= '0;
			pg_latch <= '0;
		end else begin
			if (status.clear_err) begin
				err <= '0;
				d_count <= '0;
				w_count <= '0;
			end else if (!sysen_s2 || err.err_found) begin
				d_count <= '0;
				w_count <= '0;
				delay_done <= '0;
			end else if (|settle_req) begin
				w_count <= '0;
				if (d_count == D_W'(`SETTLE_CYCLES - 1)) begin
					d_count <= '0;
					delay_done <= delay_done | settle_sel;
				end else begin
					d_count <= d_count + D_W'(1);
				end
			end else if (|wait_req) begin
				d_count <= '0;
				if (w_count == W_W'(`WATCHDOG_CYCLES - 1)) begin
					w_count <= '0;
					err.wait_err <= 1'b1;
				end else begin
					w_count <= w_count + W_W'(1);
				end
			end
			// Power-good lost on a rail that had settled
			if (|(delay_done & ~pg_s2)) begin
				err.operation_err <= 1'b1;
			end
			// Freeze the latch so it shows the state at the failure
			if ((err.wait_err || err.operation_err) && !status.clear_err) begin
				err.err_found <= 1'b1;
			end else begin
				pg_latch <= pg_s2;
			end
		end
	end

	// Up after the rail below settles, held while the rail above has power
	assign en_next = (({RC{sysen_s2}} & {delay_done[RC-2:0], 1'b1}) | {1'b0, pg_s2[RC-1:1]})
		& {RC{~err.err_found}};

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			rail_en <= '0;
			sysgood_int <= 1'b0;
			sysgood <= 1'b0;
		end else begin
			rail_en <= en_next;
			sysgood_int <= delay_done[RC-1];
			sysgood <= delay_done[RC-1] & bmc_software_pg;
		end
	end

	assign status.rail_en = rail_en;
	assign status.pg_sync = pg_s2;
	assign status.err = err;
	assign status.pg_latch = pg_latch;
	assign status.sysen_sync = sysen_s2;
	assign status.sysgood_int = sysgood_int;

	a_err_all_off: assert property (@(posedge clk_in) disable iff (!arst_n)
		err.err_found |=> (rail_en == '0));

	// Settled rails always form a run starting at rail 0
	a_done_contig: assert property (@(posedge clk_in) disable iff (!arst_n)
		(delay_done & (delay_done + power_pkg::rail_vec_t'(1))) == '0);

endmodule

/* source/reg_decode.sv */
/*
 * Byte-wide register read port. reg_sel loads the pointer, reg_rd steps it,
 * and the byte at the pointer is registered onto reg_rdata.
 * Selecting the clear-error address pulses clear_err to the sequencer.
 */
`include "pwr_seq_defines.svh"

module reg_decode (
	input logic clk_in,
	input logic arst_n,
	input logic reg_sel,
	input regs_pkg::reg_addr_t reg_addr,
	input logic reg_rd,
	input logic cpub_present,
	seq_status_if.decoder status,
	output regs_pkg::reg_byte_t reg_rdata
);

	regs_pkg::reg_addr_t ptr;
	regs_pkg::reg_addr_t rd_ptr;
	regs_pkg::reg_byte_t rd_byte;
	regs_pkg::status_byte_t stat;
	logic clear_q;

	// A read strobe returns the next byte straight away
	assign rd_ptr = reg_rd ? ptr + 8'd1 : ptr;

	assign stat = '{
		zero: 2'b00,
		cpub_present: cpub_present,
		wait_err: status.err.wait_err,
		operation_err: status.err.operation_err,
		err_found: status.err.err_found,
		sysen_sync: status.sysen_sync,
		sysgood_int: status.sysgood_int
	};

	always_comb begin
		case (rd_ptr)
			`ADDR_VERSION: rd_byte = regs_pkg::FPGA_VERSION;
			`ADDR_CLR_ERR: rd_byte = 8'hFF;
			`ADDR_PG_LATCH_HI: rd_byte = {1'b0, status.pg_latch[`RAIL_COUNT-1:8]};
			`ADDR_PG_LATCH_HI + 8'd1: rd_byte = status.pg_latch[7:0];
			`ADDR_STATUS: rd_byte = stat;
			`ADDR_EN_LO: rd_byte = status.rail_en[7:0];
			`ADDR_EN_LO + 8'd1: rd_byte = {1'b0, status.rail_en[`RAIL_COUNT-1:8]};
			`ADDR_PG_LO: rd_byte = status.pg_sync[7:0];
			`ADDR_PG_LO + 8'd1: rd_byte = {1'b0, status.pg_sync[`RAIL_COUNT-1:8]};
			`ADDR_VENDOR: rd_byte = regs_pkg::VENDOR_ID[0];
			`ADDR_VENDOR + 8'd1: rd_byte = regs_pkg::VENDOR_ID[1];
			`ADDR_VENDOR + 8'd2: rd_byte = regs_pkg::VENDOR_ID[2];
			`ADDR_VENDOR + 8'd3: rd_byte = regs_pkg::VENDOR_ID[3];
			default: rd_byte = 8'h00;
		endcase
	end

	always_ff @(posedge clk_in or negedge arst_n) begin
		if (!arst_n) begin
			ptr <= '0;
			clear_q <= 1'b0;
			reg_rdata <= '0;
		end else begin
			clear_q <= reg_sel && (reg_addr == `ADDR_CLR_ERR);
			if (reg_sel) begin
				ptr <= reg_addr;
			end else if (reg_rd) begin
				ptr <= rd_ptr;
			end
			reg_rdata <= rd_byte;
		end
	end

	assign status.clear_err = clear_q;

	// Host never selects and reads in the same cycle
	a_sel_rd_excl: assert property (@(posedge clk_in) disable iff (!arst_n)
		!(reg_sel && reg_rd));

endmodule

/* source/regs_pkg.sv */
/*
 * Register-side types and identity constants for the read port.
 * Used by the register decoder and by the testbench to build expected data.
 */
package regs_pkg;

	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_byte_t;

	localparam reg_byte_t FPGA_VERSION = 8'h06;

	// Vendor bytes, element 0 sits at the lowest vendor address
	localparam logic [3:0][7:0] VENDOR_ID = {8'h20, 8'h53, 8'h43, 8'h52};

	// Status register, MSB first
	typedef struct packed {
		logic [1:0] zero;
		logic cpub_present;
		logic wait_err;
		logic operation_err;
		logic err_found;
		logic sysen_sync;
		logic sysgood_int;
	} status_byte_t;

endpackage

/* source/seq_status_if.sv */
/*
 * Sequencer state seen by the register decoder, plus the error clear
 * pulse going back. One instance lives in the top level.
 */
interface seq_status_if;

	power_pkg::rail_vec_t rail_en;
	power_pkg::rail_vec_t pg_sync;
	power_pkg::seq_err_t err;
	power_pkg::rail_vec_t pg_latch;
	logic sysen_sync;
	logic sysgood_int;
	// Single-cycle pulse
	logic clear_err;

	modport sequencer (output rail_en, pg_sync, err, pg_latch, sysen_sync, sysgood_int,
		input clear_err);

	modport decoder (input rail_en, pg_sync, err, pg_latch, sysen_sync, sysgood_int,
		output clear_err);

endinterface

/* tb/tb_pwr_seq.sv */
/*
 * Testbench for the board power sequencer. A supply model answers each pin
 * enable after a random lag, and a scenario table runs power-up, faults,
 * error clear, register reads and power-down on the DUT.
 */
`include "pwr_seq_defines.svh"

module tb_pwr_seq;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RC = `RAIL_COUNT;
	localparam int NONE = RC;
	localparam int ROWS = 6;
	// Worst case for one full sequence in cycles
	localparam int SEQ_CYCLES = RC * (`SETTLE_CYCLES + `WATCHDOG_CYCLES + 8);
	localparam int LIMIT_NS = (ROWS * 4 * SEQ_CYCLES + 20) * 100;

	typedef struct packed {
		logic sysen;
		logic cpub;
		int hold;
		int drop;
		regs_pkg::reg_addr_t addr;
		regs_pkg::reg_byte_t stat;
		regs_pkg::reg_byte_t data;
	} row_t;

	// sysen, cpub present, withheld rail, dropped rail, address, status, data
	row_t rows [ROWS] = '{
		'{1'b1, 1'b1, NONE, NONE, `ADDR_VENDOR, 8'h23, 8'h52},
		'{1'b1, 1'b1, 5, NONE, `ADDR_EN_LO, 8'h36, 8'h00},
		'{1'b1, 1'b1, NONE, 9, `ADDR_PG_LATCH_HI, 8'h2E, 8'h7D},
		'{1'b1, 1'b0, NONE, NONE, `ADDR_PG_LO + 8'd1, 8'h03, 8'h7F},
		'{1'b1, 1'b0, 4, NONE, `ADDR_STATUS, 8'h16, 8'h16},
		'{1'b0, 1'b1, NONE, NONE, `ADDR_EN_LO, 8'h20, 8'h00}
	};

	logic clk_in;
	logic arst_n;
	logic sysen;
	logic cpub_present_n;
	logic bmc_software_pg;
	power_pkg::rail_vec_t board_pg;
	logic reg_sel;
	regs_pkg::reg_addr_t reg_addr;
	logic reg_rd;
	power_pkg::rail_vec_t board_en;
	logic cpub_clk_oe;
	logic sysgood;
	logic lpc_rst;
	regs_pkg::reg_byte_t reg_rdata;

	power_pkg::rail_vec_t hold_mask;
	power_pkg::rail_vec_t drop_mask;
	int lag [RC];
	int seed;
	int errors;
	logic cpub;

	pwr_seq_top dut_i (.*);

	initial begin
		clk_in = 1'b0;
		forever #50 clk_in = ~clk_in;
	end

	// Logical rail state seen at the pins, ATX pin is active low
	function automatic power_pkg::rail_vec_t pins_on();
		return board_en ^ power_pkg::rail_vec_t'(1);
	endfunction

	// Supply model, each power-good follows its pin enable after a lag
	initial begin
		int cnt [RC];
		power_pkg::rail_vec_t on;
		int i;
		board_pg = '0;
		for (i = 0; i < RC; i++) begin
			cnt[i] = 0;
		end
		forever begin
			@(negedge clk_in);
			on = pins_on() & ~hold_mask & ~drop_mask;
			for (i = 0; i < RC; i++) begin
				if (!on[i]) begin
					cnt[i] = 0;
				end else if (cnt[i] < lag[i]) begin
					cnt[i]++;
				end
				board_pg[i] = on[i] && (cnt[i] >= lag[i]);
			end
		end
	end

	task automatic check(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0d ns: %s got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("Timed out at %0d ns waiting for %s", $time, what);
		errors++;
	endtask

	// Data is back two cycles after the select strobe
	task automatic sel_read(input regs_pkg::reg_addr_t a, output regs_pkg::reg_byte_t d);
		reg_sel = 1'b1;
		reg_addr = a;
		@(negedge clk_in);
		reg_sel = 1'b0;
		@(negedge clk_in);
		d = reg_rdata;
	endtask

	task automatic step_read(output regs_pkg::reg_byte_t d);
		reg_rd = 1'b1;
		@(negedge clk_in);
		reg_rd = 1'b0;
		d = reg_rdata;
	endtask

	// Follows the pins until the sequence ends, checking the order of changes
	task automatic watch_sequence(input bit up);
		power_pkg::rail_vec_t prev;
		power_pkg::rail_vec_t cur;
		power_pkg::rail_vec_t care;
		power_pkg::rail_vec_t below;
		power_pkg::rail_vec_t above;
		logic ok;
		logic done;
		int i;
		int n;
		care = cpub ? '1 : ~power_pkg::cpub_rail_mask;
		prev = pins_on() & care;
		cur = prev;
		done = 1'b0;
		n = 0;
		while (!done && n < SEQ_CYCLES) begin
			@(negedge clk_in);
			cur = pins_on();
			check(16'(cur & ~care), 16'h0, "gated second-CPU pins");
			cur = cur & care;
			for (i = 0; i < RC; i++) begin
				below = (power_pkg::rail_vec_t'(1) << i) - power_pkg::rail_vec_t'(1);
				above = ~(below | (power_pkg::rail_vec_t'(1) << i));
				if (cur[i] != prev[i]) begin
					if (up) begin
						ok = cur[i] && ((prev & care & below) == (care & below));
					end else begin
						ok = !cur[i] && ((prev & above) == '0);
					end
					check(16'(ok), 16'h1, $sformatf("enable order at rail %0d", i));
				end
			end
			prev = cur;
			done = up ? lpc_rst : (cur == '0 && !sysgood && !lpc_rst);
			n++;
		end
		if (!done) begin
			note_timeout(up ? "power-up" : "power-down");
		end else if (up) begin
			check(16'(cur), 16'(care), "all enables on at power good");
		end
	endtask

	task automatic power_up();
		int n;
		bmc_software_pg = 1'b0;
		watch_sequence(1'b1);
		check(16'(sysgood), 16'h0, "sysgood held by BMC");
		bmc_software_pg = 1'b1;
		n = 0;
		while (!sysgood && n < 8) begin
			@(negedge clk_in);
			n++;
		end
		check(16'(sysgood), 16'h1, "sysgood after BMC power good");
		check(16'(lpc_rst), 16'h1, "lpc_rst with sysgood");
	endtask

	task automatic wait_error();
		regs_pkg::reg_byte_t d;
		int n;
		d = '0;
		n = 0;
		while (!d[2] && n < SEQ_CYCLES) begin
			sel_read(`ADDR_STATUS, d);
			n++;
		end
		if (!d[2]) begin
			note_timeout("the error flag");
		end
		// Enables clear a cycle after err_found, the pins one more
		repeat (2) @(negedge clk_in);
		check(16'(pins_on()), 16'h0, "all enables off after error");
	endtask

	task automatic clear_errors();
		regs_pkg::reg_byte_t d;
		hold_mask = '0;
		drop_mask = '0;
		sel_read(`ADDR_CLR_ERR, d);
		check(16'(d), 16'h00FF, "clear-error marker");
		sel_read(`ADDR_STATUS, d);
		check(16'(d & 8'h1C), 16'h0, "error flags after clear");
		power_up();
	endtask

	// Version, then every byte up to the last vendor ID byte
	task automatic sweep_regs();
		power_pkg::rail_vec_t pg;
		regs_pkg::reg_byte_t want [16];
		regs_pkg::reg_byte_t d;
		int a;
		pg = board_pg | (cpub ? '0 : power_pkg::cpub_rail_mask);
		want = '{8'h06, 8'h00, 8'h00, 8'hFF, 8'h00,
			{1'b0, pg[RC-1:8]}, pg[7:0], {2'b00, cpub, 5'b00011}, 8'hFF, 8'h7F,
			pg[7:0], {1'b0, pg[RC-1:8]}, 8'h52, 8'h43, 8'h53, 8'h20};
		sel_read(`ADDR_VERSION, d);
		check(16'(d), 16'(want[0]), "version register");
		for (a = 1; a < 16; a++) begin
			step_read(d);
			check(16'(d), 16'(want[a]), $sformatf("register %02h in sweep", a));
		end
	endtask

	initial begin
		#(LIMIT_NS);
		$display("Simulation stopped by the watchdog after %0d ns", LIMIT_NS);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		regs_pkg::reg_byte_t d;
		row_t r;
		int k;
		int i;
		int start;
		seed = 32'h08d241c5;
		errors = 0;
		arst_n = 1'b0;
		sysen = 1'b0;
		cpub_present_n = 1'b0;
		bmc_software_pg = 1'b0;
		reg_sel = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		hold_mask = '0;
		drop_mask = '0;
		cpub = 1'b1;
		for (i = 0; i < RC; i++) begin
			lag[i] = 1;
		end
		repeat (4) @(negedge clk_in);
		check(16'(board_en), 16'h0001, "pins in reset");
		check(16'({sysgood, lpc_rst, cpub_clk_oe}), 16'h0, "outputs in reset");
		check(16'(reg_rdata), 16'h0, "reg_rdata in reset");
		arst_n = 1'b1;

		for (k = 0; k < ROWS; k++) begin
			r = rows[k];
			start = errors;
			for (i = 0; i < RC; i++) begin
				lag[i] = 1 + ({$random(seed)} % 12);
			end
			cpub = r.cpub;
			cpub_present_n = ~r.cpub;
			repeat (4) @(negedge clk_in);
			check(16'(cpub_clk_oe), 16'(r.cpub), "cpub_clk_oe");
			if (r.sysen) begin
				sysen = 1'b1;
				if (r.hold < RC) begin
					hold_mask[r.hold] = 1'b1;
					wait_error();
				end else begin
					power_up();
					sweep_regs();
					if (r.drop < RC) begin
						drop_mask[r.drop] = 1'b1;
						wait_error();
					end
				end
			end else begin
				// Nothing may start without sysen
				repeat (2 * `SETTLE_CYCLES) @(negedge clk_in);
				check(16'(pins_on()), 16'h0, "enables with sysen low");
			end
			sel_read(`ADDR_STATUS, d);
			check(16'(d), 16'(r.stat), "status register");
			sel_read(r.addr, d);
			check(16'(d), 16'(r.data), $sformatf("register %02h", r.addr));
			if (r.hold < RC || r.drop < RC) begin
				clear_errors();
			end
			if (r.sysen) begin
				sysen = 1'b0;
				watch_sequence(1'b0);
				sel_read(`ADDR_STATUS, d);
				check(16'(d), {10'd0, r.cpub, 5'd0}, "status after power-down");
			end
			$display("Test %0d %s", k, (errors == start) ? "passed" : "failed");
		end

		$display("%0d tests run, %0d errors", ROWS, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
